//--- hdl/quad_interp_params.svh
`ifndef QUAD_INTERP_PARAMS_SVH
`define QUAD_INTERP_PARAMS_SVH

// points per frame through the two 2x stages
`define QI_IN_TAPS      6
`define QI_MID_TAPS     11
`define QI_OUT_TAPS     21

// one memory region per channel
`define QI_CHANNELS     2
`define QI_REGION_WORDS 32

// covers all regions of the result memory
`define QI_ADDR_W       6

`endif

//--- hdl/quad_interp_pkg.sv
`include "quad_interp_params.svh"

package quad_interp_pkg;

   // raw input sample
   typedef logic signed [7:0] sample_t;

   // working width of both stages that wraps on overflow
   typedef logic signed [8:0] interp_t;

   // stored word
   typedef logic signed [15:0] result_t;

   typedef sample_t [`QI_IN_TAPS-1:0] in_frame_t;
   typedef result_t [`QI_OUT_TAPS-1:0] out_frame_t;

   typedef logic [`QI_ADDR_W-1:0] ram_addr_t;

endpackage

//--- hdl/interp_stage.sv
`timescale 1ns/1ps

module interp_stage #(
   parameter int  N_IN  = 6,
   parameter type in_t  = logic signed [7:0],
   parameter type out_t = logic signed [8:0]
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  in_t  [N_IN-1:0]      din,
   output logic                 out_valid,
   output out_t [2*N_IN-2:0]    dout
);

   out_t [N_IN-1:0] x;
   out_t [N_IN-1:0] even_q1;
   out_t [N_IN-1:0] even_q2;
   out_t [N_IN-1:0] even_q3;
   logic [2:0]      vld_q;

   // widen before shifting so all terms share one width
   always_comb
   begin
      for (int i = 0; i < N_IN; i++)
      begin
         x[i] = out_t'(din[i]);
      end
   end

   for (genvar k = 0; k < N_IN - 1; k++)
   begin : g_odd
      out_t t38;
      out_t t34;
      out_t t18;
      out_t p38_q;
      out_t p34_q;
      out_t p18_q;
      out_t sum_q;
      out_t sub_q;
      out_t odd_q;

      if (k < N_IN - 2)
      begin : g_inner
         assign t38 = x[k];
         assign t34 = x[k + 1];
         assign t18 = x[k + 2];
      end
      else
      begin : g_edge
         // no right neighbour, so the window is mirrored
         assign t38 = x[N_IN - 1];
         assign t34 = x[N_IN - 2];
         assign t18 = x[N_IN - 3];
      end

      // 3/8 and 3/4 terms, then their sum, then minus 1/8
      always_ff @(posedge clk)
      begin
         p38_q <= (t38 >>> 2) + (t38 >>> 3);
         p34_q <= (t34 >>> 1) + (t34 >>> 2);
         p18_q <= t18 >>> 3;
         sum_q <= p38_q + p34_q;
         sub_q <= p18_q;
         odd_q <= sum_q - sub_q;
      end

      assign dout[2*k + 1] = odd_q;
   end

   // copies ride alongside the midpoint math
   always_ff @(posedge clk)
   begin
      even_q1 <= x;
      even_q2 <= even_q1;
      even_q3 <= even_q2;
   end

   for (genvar i = 0; i < N_IN; i++)
   begin : g_even
      assign dout[2*i] = even_q3[i];
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         vld_q <= '0;
      end
      else
      begin
         vld_q <= {vld_q[1:0], in_valid};
      end
   end

   assign out_valid = vld_q[2];

endmodule

//--- hdl/quad_interp.sv
`timescale 1ns/1ps
`include "quad_interp_params.svh"

module quad_interp (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        new_data,
   input  quad_interp_pkg::in_frame_t  din,
   output logic                        out_valid,
   output quad_interp_pkg::out_frame_t dout
);

   import quad_interp_pkg::*;

   in_frame_t                  din_q;
   logic                       cap_vld_q;
   logic                       mid_valid;
   interp_t [`QI_MID_TAPS-1:0] mid;
   logic                       fine_valid;
   interp_t [`QI_OUT_TAPS-1:0] fine;

   always_ff @(posedge clk)
   begin
      if (new_data)
      begin
         din_q <= din;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cap_vld_q <= 1'b0;
         out_valid <= 1'b0;
      end
      else
      begin
         cap_vld_q <= new_data;
         out_valid <= fine_valid;
      end
   end

   // 6 -> 11 points
   interp_stage #(
      .N_IN  (`QI_IN_TAPS),
      .in_t  (sample_t),
      .out_t (interp_t)
   ) u_stage1 (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (cap_vld_q),
      .din       (din_q),
      .out_valid (mid_valid),
      .dout      (mid)
   );

   // 11 -> 21 points
   interp_stage #(
      .N_IN  (`QI_MID_TAPS),
      .in_t  (interp_t),
      .out_t (interp_t)
   ) u_stage2 (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (mid_valid),
      .din       (mid),
      .out_valid (fine_valid),
      .dout      (fine)
   );

   // sign extend to the stored width
   always_ff @(posedge clk)
   begin
      if (fine_valid)
      begin
         for (int i = 0; i < `QI_OUT_TAPS; i++)
         begin
            dout[i] <= result_t'(fine[i]);
         end
      end
   end

endmodule

//--- hdl/frame_writer.sv
`timescale 1ns/1ps
`include "quad_interp_params.svh"

module frame_writer #(
   parameter quad_interp_pkg::ram_addr_t BASE = '0
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        out_valid,
   input  quad_interp_pkg::out_frame_t dout,
   input  logic                        grant,
   output logic                        req,
   output quad_interp_pkg::ram_addr_t  wr_addr,
   output quad_interp_pkg::result_t    wr_data,
   output logic                        frame_done,
   output logic                        overflow
);

   import quad_interp_pkg::*;

   localparam int IDX_W = $clog2(`QI_OUT_TAPS);

   out_frame_t       frame_q;
   logic [IDX_W-1:0] idx_q;
   logic             busy_q;
   logic             last_word;

   assign last_word  = idx_q == IDX_W'(`QI_OUT_TAPS - 1);
   assign req        = busy_q;
   assign wr_addr    = BASE + ram_addr_t'(idx_q);
   assign wr_data    = frame_q[idx_q];
   assign frame_done = busy_q && grant && last_word;

   // one frame held while its words drain
   always_ff @(posedge clk)
   begin
      if (out_valid && !busy_q)
      begin
         frame_q <= dout;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         busy_q   <= 1'b0;
         idx_q    <= '0;
         overflow <= 1'b0;
      end
      else if (!busy_q)
      begin
         if (out_valid)
         begin
            busy_q <= 1'b1;
         end
      end
      else
      begin
         // frame arriving mid-transfer is lost
         if (out_valid)
         begin
            overflow <= 1'b1;
         end
         if (grant)
         begin
            idx_q <= last_word ? '0 : idx_q + 1'b1;
            if (last_word)
            begin
               busy_q <= 1'b0;
            end
         end
      end
   end

endmodule

//--- hdl/ram_arbiter.sv
`timescale 1ns/1ps
`include "quad_interp_params.svh"

module ram_arbiter (
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic [`QI_CHANNELS-1:0]                      req,
   input  quad_interp_pkg::ram_addr_t [`QI_CHANNELS-1:0] wr_addr,
   input  quad_interp_pkg::result_t [`QI_CHANNELS-1:0]   wr_data,
   output logic [`QI_CHANNELS-1:0]                      grant,
   output logic                                         we,
   output quad_interp_pkg::ram_addr_t                   addr,
   output quad_interp_pkg::result_t                     wdata
);

   localparam int N     = `QI_CHANNELS;
   localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

   logic [PTR_W-1:0] last_q;
   logic [PTR_W-1:0] win;

   // search starts just past the last winner
   always_comb
   begin
      int   cand;
      logic found;
      grant = '0;
      win   = last_q;
      found = 1'b0;
      for (int i = 1; i <= N; i++)
      begin
         cand = (int'(last_q) + i) % N;
         if (!found && req[cand])
         begin
            grant[cand] = 1'b1;
            win         = PTR_W'(cand);
            found       = 1'b1;
         end
      end
   end

   assign we    = |req;
   assign addr  = wr_addr[win];
   assign wdata = wr_data[win];

   // channel 0 goes first out of reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         last_q <= PTR_W'(N - 1);
      end
      else if (we)
      begin
         last_q <= win;
      end
   end

endmodule

//--- hdl/result_ram.sv
`timescale 1ns/1ps
`include "quad_interp_params.svh"

module result_ram (
   input  logic                       clk,
   input  logic                       we,
   input  quad_interp_pkg::ram_addr_t addr,
   input  quad_interp_pkg::result_t   wdata,
   input  quad_interp_pkg::ram_addr_t rd_addr,
   output quad_interp_pkg::result_t   rd_data
);

   import quad_interp_pkg::*;

   localparam int DEPTH = 2 ** `QI_ADDR_W;

   result_t mem [DEPTH];

   // read returns the old word on a same-address write
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[addr] <= wdata;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

//--- hdl/interp_subsystem.sv
`timescale 1ns/1ps
`include "quad_interp_params.svh"

module interp_subsystem (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`QI_CHANNELS-1:0]    new_data,
   input  quad_interp_pkg::in_frame_t din0,
   input  quad_interp_pkg::in_frame_t din1,
   input  quad_interp_pkg::ram_addr_t rd_addr,
   output quad_interp_pkg::result_t   rd_data,
   output logic [`QI_CHANNELS-1:0]    frame_done,
   output logic [`QI_CHANNELS-1:0]    overflow
);

   import quad_interp_pkg::*;

   in_frame_t  [`QI_CHANNELS-1:0] din;
   logic       [`QI_CHANNELS-1:0] frame_valid;
   out_frame_t [`QI_CHANNELS-1:0] frame;
   logic       [`QI_CHANNELS-1:0] req;
   logic       [`QI_CHANNELS-1:0] grant;
   ram_addr_t  [`QI_CHANNELS-1:0] wr_addr;
   result_t    [`QI_CHANNELS-1:0] wr_data;
   logic                          we;
   ram_addr_t                     addr;
   result_t                       wdata;

   assign din = {din1, din0};

   for (genvar c = 0; c < `QI_CHANNELS; c++)
   begin : g_chan
      quad_interp u_interp (
         .clk       (clk),
         .rst_n     (rst_n),
         .new_data  (new_data[c]),
         .din       (din[c]),
         .out_valid (frame_valid[c]),
         .dout      (frame[c])
      );

      // each channel owns its own region of the memory
      frame_writer #(
         .BASE (ram_addr_t'(c * `QI_REGION_WORDS))
      ) u_writer (
         .clk        (clk),
         .rst_n      (rst_n),
         .out_valid  (frame_valid[c]),
         .dout       (frame[c]),
         .grant      (grant[c]),
         .req        (req[c]),
         .wr_addr    (wr_addr[c]),
         .wr_data    (wr_data[c]),
         .frame_done (frame_done[c]),
         .overflow   (overflow[c])
      );
   end

   ram_arbiter u_arbiter (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .grant   (grant),
      .we      (we),
      .addr    (addr),
      .wdata   (wdata)
   );

   result_ram u_ram (
      .clk     (clk),
      .we      (we),
      .addr    (addr),
      .wdata   (wdata),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

//--- tests/tb_interp_subsystem.sv
`timescale 1ns/1ps
`include "quad_interp_params.svh"

module tb_interp_subsystem;

   import quad_interp_pkg::*;

   localparam int TIMEOUT = 200;

   logic                    clk;
   logic                    rst_n;
   logic [`QI_CHANNELS-1:0] new_data;
   in_frame_t               din0;
   in_frame_t               din1;
   ram_addr_t               rd_addr;
   result_t                 rd_data;
   logic [`QI_CHANNELS-1:0] frame_done;
   logic [`QI_CHANNELS-1:0] overflow;

   logic [31:0] lfsr = 32'h8710;
   int          checks = 0;
   int          errors = 0;

   interp_subsystem u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .new_data   (new_data),
      .din0       (din0),
      .din1       (din1),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .frame_done (frame_done),
      .overflow   (overflow)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // taps 32 22 2 1
   function automatic logic next_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic sample_t rand_sample();
      sample_t s;
      for (int b = 0; b < 8; b++)
      begin
         s[b] = next_bit();
      end
      return s;
   endfunction

   // one midpoint with every partial wrapped at 9 bits
   function automatic interp_t odd_point(input interp_t w38, input interp_t w34,
                                         input interp_t w18);
      interp_t p38;
      interp_t p34;
      interp_t p18;
      p38 = (w38 >>> 2) + (w38 >>> 3);
      p34 = (w34 >>> 1) + (w34 >>> 2);
      p18 = w18 >>> 3;
      return p38 + p34 - p18;
   endfunction

   function automatic out_frame_t model_frame(input in_frame_t f);
      interp_t    a [`QI_OUT_TAPS];
      interp_t    b [`QI_OUT_TAPS];
      out_frame_t r;
      int         n;
      for (int i = 0; i < `QI_OUT_TAPS; i++)
      begin
         a[i] = '0;
         b[i] = '0;
      end
      for (int i = 0; i < `QI_IN_TAPS; i++)
      begin
         a[i] = {f[i][7], f[i]};
      end
      n = `QI_IN_TAPS;
      for (int s = 0; s < 2; s++)
      begin
         for (int k = 0; k < n; k++)
         begin
            b[2*k] = a[k];
         end
         for (int k = 0; k < n - 2; k++)
         begin
            b[2*k + 1] = odd_point(a[k], a[k + 1], a[k + 2]);
         end
         b[2*n - 3] = odd_point(a[n - 1], a[n - 2], a[n - 3]);
         for (int i = 0; i < 2*n - 1; i++)
         begin
            a[i] = b[i];
         end
         n = 2*n - 1;
      end
      for (int j = 0; j < `QI_OUT_TAPS; j++)
      begin
         r[j] = {{7{a[j][8]}}, a[j]};
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst_n    <= 1'b0;
      new_data <= '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   // collects done pulses of all channels in mask
   task automatic wait_done(input logic [`QI_CHANNELS-1:0] mask);
      logic [`QI_CHANNELS-1:0] seen;
      int                      n;
      seen = '0;
      n    = 0;
      while (seen != mask && n < TIMEOUT)
      begin
         @(negedge clk);
         seen = seen | (frame_done & mask);
         n++;
      end
      if (seen != mask)
      begin
         errors++;
         $display("timeout: frame_done mask %b never completed, saw %b", mask, seen);
      end
   endtask

   task automatic check_region(input int ch, input in_frame_t f);
      out_frame_t exp;
      exp = model_frame(f);
      for (int j = 0; j < `QI_OUT_TAPS; j++)
      begin
         @(posedge clk);
         rd_addr <= ram_addr_t'(ch * `QI_REGION_WORDS + j);
         @(posedge clk);
         @(negedge clk);
         check($sformatf("rd_data[ch%0d w%0d]", ch, j), 32'(rd_data), 32'(exp[j]));
      end
   endtask

   task automatic run_frames(input logic [`QI_CHANNELS-1:0] mask, input in_frame_t f0,
                             input in_frame_t f1);
      @(posedge clk);
      din0     <= f0;
      din1     <= f1;
      new_data <= mask;
      @(posedge clk);
      new_data <= '0;
      wait_done(mask);
      if (mask[0])
      begin
         check_region(0, f0);
      end
      if (mask[1])
      begin
         check_region(1, f1);
      end
   endtask

   task automatic end_test(input int num, input string name, input int err_before);
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
   endtask

   task automatic single_frame();
      in_frame_t f;
      int        e;
      e = errors;
      for (int i = 0; i < `QI_IN_TAPS; i++)
      begin
         f[i] = sample_t'(i * 20 - 50);
      end
      run_frames(2'b01, f, '0);
      end_test(1, "single frame", e);
   endtask

   task automatic both_channels();
      in_frame_t f0;
      in_frame_t f1;
      int        e;
      e = errors;
      for (int i = 0; i < `QI_IN_TAPS; i++)
      begin
         f0[i] = sample_t'(90 - i * 33);
         f1[i] = sample_t'((i % 2 == 0) ? i * 7 : -i * 11);
      end
      run_frames(2'b11, f0, f1);
      end_test(2, "both channels", e);
   endtask

   task automatic extreme_values();
      in_frame_t f0;
      in_frame_t f1;
      int        e;
      e  = errors;
      f1 = {sample_t'(-100), sample_t'(-77), sample_t'(-3),
            sample_t'(-128), sample_t'(-50), sample_t'(-1)};
      for (int i = 0; i < `QI_IN_TAPS; i++)
      begin
         f0[i] = (i % 2 == 0) ? 8'sh80 : 8'sh7f;
      end
      run_frames(2'b11, f0, f1);
      end_test(3, "extreme values", e);
   endtask

   task automatic overflow_drop();
      in_frame_t fa;
      in_frame_t fb;
      int        e;
      e = errors;
      for (int i = 0; i < `QI_IN_TAPS; i++)
      begin
         fa[i] = sample_t'(i * 13 + 5);
         fb[i] = sample_t'(-i * 9);
      end
      // second strobe lands while the writer is busy
      @(posedge clk);
      din1     <= fa;
      new_data <= 2'b10;
      @(posedge clk);
      din1 <= fb;
      @(posedge clk);
      new_data <= '0;
      wait_done(2'b10);
      check_region(1, fa);
      @(negedge clk);
      check("overflow", 32'(overflow), 32'(2'b10));
      apply_reset();
      @(negedge clk);
      check("overflow", 32'(overflow), 32'(2'b00));
      check("frame_done", 32'(frame_done), 32'(2'b00));
      end_test(4, "pipelining and overflow", e);
   endtask

   task automatic random_frames();
      in_frame_t f0;
      in_frame_t f1;
      int        e;
      e = errors;
      for (int n = 0; n < 8; n++)
      begin
         for (int i = 0; i < `QI_IN_TAPS; i++)
         begin
            f0[i] = rand_sample();
         end
         for (int i = 0; i < `QI_IN_TAPS; i++)
         begin
            f1[i] = rand_sample();
         end
         run_frames(2'b11, f0, f1);
      end
      end_test(5, "random frames", e);
   endtask

   initial
   begin
      rst_n    = 1'b0;
      new_data = '0;
      din0     = '0;
      din1     = '0;
      rd_addr  = '0;
      apply_reset();
      single_frame();
      both_channels();
      extreme_values();
      overflow_drop();
      random_frames();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- interp_subsystem.f
+incdir+hdl
hdl/quad_interp_pkg.sv
hdl/interp_stage.sv
hdl/quad_interp.sv
hdl/frame_writer.sv
hdl/ram_arbiter.sv
hdl/result_ram.sv
hdl/interp_subsystem.sv
tests/tb_interp_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_interp_subsystem
FILELIST  := interp_subsystem.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
